// File: logic/lsu_pkg.sv
// aligned-only build, so word accesses ignore address bits 1:0 and halfwords use bit 1
// data and address are fixed at 32 bits
package lsu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int unsigned LSU_WORD_W = 32;  // data and address width

  ////////////////////////////////////////
  // access size encoding
  ////////////////////////////////////////

  // matches the execute stage data_type field
  typedef enum logic [1:0] {
    LSU_TYPE_WORD  = 2'b00,  // 32 bit
    LSU_TYPE_HALF  = 2'b01,  // 16 bit
    LSU_TYPE_BYTE  = 2'b10,  // 8 bit
    LSU_TYPE_BYTE2 = 2'b11   // also 8 bit, second encoding
  } lsu_type_e;

  // byte offset inside a word, low address bits
  typedef logic [1:0] lsu_off_t;

  ////////////////////////////////////////
  // memory word views
  ////////////////////////////////////////

  // one bus word seen as byte lanes or halfword lanes
  // lane 0 sits at bits 7:0 (little endian)
  typedef union packed {
    logic [LSU_WORD_W/8-1:0][7:0]   b;  // four byte lanes
    logic [LSU_WORD_W/16-1:0][15:0] h;  // two halfword lanes
  } lsu_word_u;

endpackage

// File: logic/lsu_addr_stage.sv
// execute-stage address path, purely combinational
// no misaligned splits and no register offset for stores
`timescale 1ns/1ps

module lsu_addr_stage
  import lsu_pkg::*;
(
  input  logic [LSU_WORD_W-1:0] operand_a_ex_i,   // base from rs1
  input  logic [LSU_WORD_W-1:0] operand_b_ex_i,   // immediate or rs2
  input  lsu_type_e             data_type_ex_i,   // access size
  input  logic [LSU_WORD_W-1:0] data_wdata_ex_i,  // store data, byte 0 in bits 7:0

  output logic [LSU_WORD_W-1:0] data_addr_o,      // to memory
  output logic [3:0]            data_be_o,        // lane enables to memory
  output lsu_word_u             data_wdata_o,     // lane-rotated store data
  output lsu_off_t              addr_off_o        // to load aligner
);

  logic [LSU_WORD_W-1:0] addr_sum;   // a + b
  lsu_off_t              addr_off;   // byte offset of the access
  lsu_word_u             wdata_src;  // store data as lanes
  lsu_word_u             wdata_rot;  // rotated onto addressed lanes
  logic [3:0]            be;

  ////////////////////////////////////////
  // address
  ////////////////////////////////////////

  assign addr_sum  = operand_a_ex_i + operand_b_ex_i;
  assign addr_off  = addr_sum[1:0];  // only the low bits steer lanes
  assign wdata_src = data_wdata_ex_i;

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb
  begin
    be = 4'b0000;
    case (data_type_ex_i)
      LSU_TYPE_WORD:
      begin
        be = 4'b1111;  // offset ignored
      end
      LSU_TYPE_HALF:
      begin
        // bit 0 ignored, bit 1 picks the pair
        if (addr_off[1])
          be = 4'b1100;
        else
          be = 4'b0011;
      end
      LSU_TYPE_BYTE, LSU_TYPE_BYTE2:
      begin
        be = 4'b0001 << addr_off;  // one hot lane
      end
      default:
      begin
        be = 4'b0000;
      end
    endcase
  end

  ////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////

  // rotate left by offset bytes
  // register byte 0 ends up in lane addr_off, the rest wraps around
  always_comb
  begin
    lsu_off_t src_lane;
    wdata_rot = '0;
    for (int lane = 0; lane < LSU_WORD_W/8; lane++)
    begin
      src_lane          = lsu_off_t'(lane) - addr_off;  // wraps mod 4
      wdata_rot.b[lane] = wdata_src.b[src_lane];
    end
  end

  // outputs
  assign data_addr_o  = addr_sum;
  assign data_be_o    = be;
  assign data_wdata_o = wdata_rot;
  assign addr_off_o   = addr_off;  // captured by the aligner on grant

endmodule

// File: logic/lsu_req_ctrl.sv
// request FSM for req/gnt/rvalid memories with at most one access outstanding
// errors are only sampled together with a grant
`timescale 1ns/1ps

module lsu_req_ctrl
(
  input  logic clk,
  input  logic rst_n,

  // execute side
  input  logic data_req_ex_i,   // core wants an access
  input  logic data_we_ex_i,    // 1 store, 0 load
  input  logic ex_valid_i,      // execute stage moves on this cycle

  // memory side
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,      // valid with grant only

  output logic data_req_o,
  output logic lsu_ready_ex_o,  // low while a request waits for grant
  output logic lsu_ready_wb_o,  // low while wb waits for rvalid
  output logic busy_o,
  output logic load_err_o,
  output logic store_err_o
);

  typedef enum logic [1:0] {
    IDLE,                  // nothing outstanding
    WAIT_RVALID,           // granted, wb waits for data
    WAIT_RVALID_EX_STALL,  // granted while ex stalled
    IDLE_EX_STALL          // data back, ex still stalled
  } state_e;

  state_e state_q;
  state_e state_d;
  state_e grant_state;  // where a granted request goes

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // an ex stall in the grant cycle means the core has not taken the result
  assign grant_state = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;

  ////////////////////////////////////////
  // next state and handshake
  ////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        data_req_o = data_req_ex_i;
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;  // hold ex until granted
          if (data_gnt_i)
            state_d = grant_state;
        end
      end

      WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;
        if (data_rvalid_i)
        begin
          // back to back issue in the rvalid cycle
          data_req_o = data_req_ex_i;
          state_d    = IDLE;
          if (data_req_ex_i)
          begin
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = grant_state;
          end
        end
      end

      WAIT_RVALID_EX_STALL:
      begin
        // no new request here, ex still holds the old access
        if (data_rvalid_i)
        begin
          if (ex_valid_i)
            state_d = IDLE;
          else
            state_d = IDLE_EX_STALL;
        end
        else if (ex_valid_i)
        begin
          state_d = WAIT_RVALID;  // stall gone, normal wait
        end
      end

      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;  // core finally moved on
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // status and errors
  ////////////////////////////////////////

  assign busy_o = (state_q != IDLE) || data_req_o;

  // same cycle as the faulting grant
  assign load_err_o  = data_gnt_i & data_err_i & ~data_we_ex_i;
  assign store_err_o = data_gnt_i & data_err_i & data_we_ex_i;

endmodule

// File: logic/lsu_load_align.sv
// load data extraction from the granted access attributes
// aligned accesses only, the result is held until the next load rvalid
`timescale 1ns/1ps

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  data_gnt_i,          // capture strobe
  input  logic                  data_rvalid_i,       // result strobe
  input  logic                  data_we_ex_i,        // 1 store
  input  logic                  data_sign_ext_ex_i,  // 1 sign extend
  input  lsu_type_e             data_type_ex_i,
  input  lsu_off_t              addr_off_i,          // from address stage
  input  lsu_word_u             data_rdata_i,        // raw memory word

  output logic [LSU_WORD_W-1:0] data_rdata_ex_o      // to register file
);

  // attributes of the outstanding access
  lsu_type_e             type_q;
  lsu_off_t              off_q;
  logic                  sign_ext_q;
  logic                  we_q;

  logic [15:0]           half_sel;   // selected halfword lane
  logic [7:0]            byte_sel;   // selected byte lane
  logic [LSU_WORD_W-1:0] rdata_ext;  // extended result
  logic [LSU_WORD_W-1:0] rdata_q;    // last load result

  ////////////////////////////////////////
  // attribute capture on grant
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q     <= LSU_TYPE_WORD;
      off_q      <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      type_q     <= data_type_ex_i;
      off_q      <= addr_off_i;
      sign_ext_q <= data_sign_ext_ex_i;
      we_q       <= data_we_ex_i;
    end
  end

  ////////////////////////////////////////
  // lane select and extension
  ////////////////////////////////////////

  assign half_sel = data_rdata_i.h[off_q[1]];  // bit 0 ignored
  assign byte_sel = data_rdata_i.b[off_q];

  always_comb
  begin
    case (type_q)
      LSU_TYPE_WORD:
        rdata_ext = data_rdata_i;  // pass as is
      LSU_TYPE_HALF:
        rdata_ext = {{(LSU_WORD_W-16){sign_ext_q & half_sel[15]}}, half_sel};
      LSU_TYPE_BYTE, LSU_TYPE_BYTE2:
        rdata_ext = {{(LSU_WORD_W-8){sign_ext_q & byte_sel[7]}}, byte_sel};
      default:
        rdata_ext = data_rdata_i;
    endcase
  end

  ////////////////////////////////////////
  // result hold
  ////////////////////////////////////////

  // store rvalids leave the held load value alone
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !we_q)
      rdata_q <= rdata_ext;
  end

  // live in the rvalid cycle, registered afterwards
  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

// File: logic/load_store_unit.sv
// aligned-only LSU between execute stage and a req/gnt/rvalid data memory
// one outstanding access, the core holds its inputs until lsu_ready_ex_o
`timescale 1ns/1ps

module load_store_unit
  import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // execute side
  input  logic                  data_req_ex_i,
  input  logic                  data_we_ex_i,
  input  lsu_type_e             data_type_ex_i,
  input  logic                  data_sign_ext_ex_i,
  input  logic [LSU_WORD_W-1:0] data_wdata_ex_i,
  input  logic [LSU_WORD_W-1:0] operand_a_ex_i,
  input  logic [LSU_WORD_W-1:0] operand_b_ex_i,
  input  logic                  ex_valid_i,

  output logic [LSU_WORD_W-1:0] data_rdata_ex_o,
  output logic                  lsu_ready_ex_o,
  output logic                  lsu_ready_wb_o,
  output logic                  busy_o,
  output logic                  load_err_o,
  output logic                  store_err_o,

  // memory side
  output logic                  data_req_o,
  output logic [LSU_WORD_W-1:0] data_addr_o,
  output logic                  data_we_o,
  output logic [3:0]            data_be_o,
  output logic [LSU_WORD_W-1:0] data_wdata_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic [LSU_WORD_W-1:0] data_rdata_i,
  input  logic                  data_err_i
);

  lsu_off_t addr_off;  // low address bits for the aligner

  ////////////////////////////////////////
  // address, enables, store data
  ////////////////////////////////////////

  lsu_addr_stage i_addr_stage (
    .operand_a_ex_i  (operand_a_ex_i),
    .operand_b_ex_i  (operand_b_ex_i),
    .data_type_ex_i  (data_type_ex_i),
    .data_wdata_ex_i (data_wdata_ex_i),
    .data_addr_o     (data_addr_o),
    .data_be_o       (data_be_o),
    .data_wdata_o    (data_wdata_o),
    .addr_off_o      (addr_off)
  );

  assign data_we_o = data_we_ex_i;  // direction straight from ex

  ////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////

  lsu_req_ctrl i_req_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_we_ex_i   (data_we_ex_i),
    .ex_valid_i     (ex_valid_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o)
  );

  // load path
  lsu_load_align i_load_align (
    .clk                (clk),
    .rst_n              (rst_n),
    .data_gnt_i         (data_gnt_i),
    .data_rvalid_i      (data_rvalid_i),
    .data_we_ex_i       (data_we_ex_i),
    .data_sign_ext_ex_i (data_sign_ext_ex_i),
    .data_type_ex_i     (data_type_ex_i),
    .addr_off_i         (addr_off),
    .data_rdata_i       (data_rdata_i),
    .data_rdata_ex_o    (data_rdata_ex_o)
  );

endmodule

// File: tb/lsu_mem_model.sv
// word memory behind a req/gnt/rvalid port, one access outstanding at a time
// addresses at or above ERR_BASE fault on grant and leave memory untouched
`timescale 1ns/1ps

module lsu_mem_model #(
  parameter int unsigned MEM_WORDS = 64,
  parameter logic [31:0] ERR_BASE  = 32'h8000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  input  logic [1:0]  gnt_dly_i,     // cycles a request waits before grant
  input  logic [1:0]  rvalid_dly_i,  // grant to rvalid, 1 to 3
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  logic [31:0] mem [MEM_WORDS];
  logic [1:0]  wait_q;    // cycles the current request has waited
  logic [1:0]  rv_cnt_q;  // cycles left until rvalid
  logic        pend_q;    // access outstanding
  logic        err_q;     // outstanding access faulted
  int unsigned idx_q;
  int unsigned idx;

  assign idx      = (addr_i >> 2) % MEM_WORDS;
  assign rvalid_o = pend_q && (rv_cnt_q == 2'd0);
  // a new grant no earlier than the rvalid of the last one
  assign gnt_o    = req_i && (!pend_q || rvalid_o) && (wait_q >= gnt_dly_i);
  assign err_o    = gnt_o && (addr_i >= ERR_BASE);
  assign rdata_o  = (rvalid_o && !err_q) ? mem[idx_q] : '0;  // faults read as zero

  // fill pattern from the byte address
  initial
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = {16'(~(i * 4)), 16'(i * 4)};

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wait_q   <= '0;
      rv_cnt_q <= '0;
      pend_q   <= 1'b0;
      err_q    <= 1'b0;
      idx_q    <= 0;
    end
    else
    begin
      if (gnt_o || !req_i)
        wait_q <= '0;
      else if (wait_q != 2'd3)
        wait_q <= wait_q + 2'd1;

      if (gnt_o)
      begin
        pend_q   <= 1'b1;
        rv_cnt_q <= rvalid_dly_i - 2'd1;
        err_q    <= err_o;
        idx_q    <= idx;
        if (we_i && !err_o)
          for (int b = 0; b < 4; b++)
            if (be_i[b])
              mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
      end
      else if (rvalid_o)
        pend_q <= 1'b0;
      else if (pend_q)
        rv_cnt_q <= rv_cnt_q - 2'd1;
    end
  end

endmodule

// File: tb/tb_load_store_unit.sv
// cases come from tb/lsu_cases.txt, run from the project root
// memory delays and ex stalls follow an xorshift sequence
`timescale 1ns/1ps

module tb_load_store_unit
  import lsu_pkg::*;
();

  localparam int unsigned NUM_FIELDS = 10;
  localparam int unsigned MAX_CASES  = 40;
  localparam int unsigned MEM_WORDS  = 64;
  localparam logic [31:0] ERR_BASE   = 32'h8000_0000;  // bit 31 set faults
  localparam int unsigned TIMEOUT    = 40;             // cycles per wait
  localparam logic [31:0] SEED       = 32'd47704;

  // column order of one case line
  typedef enum int {F_OP, F_TYPE, F_SIGN, F_A, F_B, F_WDATA, F_BE, F_LANES, F_RDATA, F_ERR} field_e;

  logic                  clk;
  logic                  rst_n;
  logic                  data_req_ex_i;
  logic                  data_we_ex_i;
  lsu_type_e             data_type_ex_i;
  logic                  data_sign_ext_ex_i;
  logic [LSU_WORD_W-1:0] data_wdata_ex_i;
  logic [LSU_WORD_W-1:0] operand_a_ex_i;
  logic [LSU_WORD_W-1:0] operand_b_ex_i;
  logic                  ex_valid_i;
  logic [LSU_WORD_W-1:0] data_rdata_ex_o;
  logic                  lsu_ready_ex_o;
  logic                  lsu_ready_wb_o;
  logic                  busy_o;
  logic                  load_err_o;
  logic                  store_err_o;
  logic                  data_req_o;
  logic [LSU_WORD_W-1:0] data_addr_o;
  logic                  data_we_o;
  logic [3:0]            data_be_o;
  logic [LSU_WORD_W-1:0] data_wdata_o;
  logic                  data_gnt_i;
  logic                  data_rvalid_i;
  logic [LSU_WORD_W-1:0] data_rdata_i;
  logic                  data_err_i;

  logic [1:0]  gnt_dly;
  logic [1:0]  rvalid_dly;
  logic [31:0] rng_state;
  logic [31:0] case_words [NUM_FIELDS*MAX_CASES];
  logic [31:0] last_load;   // value data_rdata_ex_o has to hold
  int          n_cases;
  int          n_checks;
  int          n_errors;
  int          n_timeouts;
  int          issue_q [$];  // driven, not yet granted
  int          resp_q [$];   // granted, rvalid pending

  load_store_unit i_load_store_unit (.*);

  lsu_mem_model #(.MEM_WORDS(MEM_WORDS), .ERR_BASE(ERR_BASE)) i_mem_model (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (data_req_o),
    .addr_i       (data_addr_o),
    .we_i         (data_we_o),
    .be_i         (data_be_o),
    .wdata_i      (data_wdata_o),
    .gnt_dly_i    (gnt_dly),
    .rvalid_dly_i (rvalid_dly),
    .gnt_o        (data_gnt_i),
    .rvalid_o     (data_rvalid_i),
    .rdata_o      (data_rdata_i),
    .err_o        (data_err_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [31:0] field(int c, field_e f);
    return case_words[c*NUM_FIELDS + int'(f)];
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp, int c);
    n_checks++;
    assert (got === exp)
    else
    begin
      n_errors++;
      $display("** Error: %s = 0x%h, expected 0x%h (case %0d)", name, got, exp, c);
    end
  endtask

  task automatic check_true(logic cond, string what);
    n_checks++;
    assert (cond)
    else
    begin
      n_errors++;
      $display("failure: %s", what);
    end
  endtask

  task automatic end_run();
    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  ////////////////////////////////////////
  // stimulus in the role of the core
  ////////////////////////////////////////

  initial
  begin
    logic [31:0] rnd;
    logic [31:0] ftype;
    logic        stall;
    int          waited;
    n_checks           = 0;
    n_errors           = 0;
    n_timeouts         = 0;
    rng_state          = SEED;
    last_load          = '0;
    rst_n              = 1'b0;
    data_req_ex_i      = 1'b0;
    data_we_ex_i       = 1'b0;
    data_type_ex_i     = LSU_TYPE_WORD;
    data_sign_ext_ex_i = 1'b0;
    data_wdata_ex_i    = '0;
    operand_a_ex_i     = '0;
    operand_b_ex_i     = '0;
    ex_valid_i         = 1'b1;
    gnt_dly            = 2'd0;
    rvalid_dly         = 2'd1;
    foreach (case_words[i])
      case_words[i] = '1;  // all ones marks the end
    $readmemh("tb/lsu_cases.txt", case_words);
    n_cases = 0;
    while (n_cases < MAX_CASES && field(n_cases, F_OP) != '1)
      n_cases++;
    check_true(n_cases > 0, "no cases read from tb/lsu_cases.txt");
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("data_req_o", data_req_o, 0, -1);      // idle after reset
    check_value("busy_o", busy_o, 0, -1);
    check_value("load_err_o", load_err_o, 0, -1);
    check_value("store_err_o", store_err_o, 0, -1);
    check_value("lsu_ready_ex_o", lsu_ready_ex_o, 1, -1);
    check_value("lsu_ready_wb_o", lsu_ready_wb_o, 1, -1);
    for (int c = 0; c < n_cases; c++)
    begin
      rnd   = next_rand();
      stall = (rnd[3:2] == 2'b00);  // about one in four
      ftype = field(c, F_TYPE);
      @(posedge clk);
      gnt_dly            <= rnd[1:0];
      rvalid_dly         <= 2'd1 + 2'(rnd[7:4] % 3);
      data_req_ex_i      <= 1'b1;
      data_we_ex_i       <= field(c, F_OP) != 0;
      data_type_ex_i     <= lsu_type_e'(ftype[1:0]);
      data_sign_ext_ex_i <= field(c, F_SIGN) != 0;
      operand_a_ex_i     <= field(c, F_A);
      operand_b_ex_i     <= field(c, F_B);
      data_wdata_ex_i    <= field(c, F_WDATA);
      ex_valid_i         <= !stall;
      issue_q.push_back(c);
      waited = 0;
      do
      begin
        @(negedge clk);
        waited++;
      end
      while (!data_gnt_i && waited < TIMEOUT);
      if (!data_gnt_i)
      begin
        n_timeouts++;
        $display("timeout: case %0d was never granted", c);
        end_run();
      end
      if (stall)
      begin
        // ex still holds the granted access, request line stays up
        repeat (1 + rnd[9:8])
        begin
          @(negedge clk);
          check_true(busy_o && !data_req_o, "busy_o low or a request issued in an ex stall");
        end
        @(posedge clk);
        ex_valid_i <= 1'b1;
      end
    end
    @(posedge clk);
    data_req_ex_i <= 1'b0;
    waited = 0;
    do
    begin
      @(negedge clk);
      waited++;
    end
    while ((busy_o || resp_q.size() != 0) && waited < TIMEOUT);
    if (busy_o || resp_q.size() != 0)
    begin
      n_timeouts++;
      $display("timeout: the LSU did not drain after the last case");
    end
    end_run();
  end

  ////////////////////////////////////////
  // memory side and result checks
  ////////////////////////////////////////

  always @(negedge clk)
  begin
    int c;
    if (rst_n)
    begin
      if (data_req_o && !data_gnt_i)
        check_value("lsu_ready_ex_o", lsu_ready_ex_o, 0, -1);  // back-pressure
      if (data_rvalid_i)
      begin
        check_true(resp_q.size() != 0, "rvalid with no access outstanding");
        if (resp_q.size() != 0)
        begin
          c = resp_q.pop_front();
          if (field(c, F_OP) == 0)
          begin
            check_value("data_rdata_ex_o", data_rdata_ex_o, field(c, F_RDATA), c);
            last_load = field(c, F_RDATA);
          end
        end
      end
      else
        check_value("data_rdata_ex_o", data_rdata_ex_o, last_load, -1);  // held
      // one outstanding access, a new request only once the last rvalid is in
      if (data_req_o)
        check_true(resp_q.size() == 0, "request issued before the previous rvalid");
      if (data_gnt_i)
      begin
        if (issue_q.size() == 0)
          check_true(1'b0, "grant without a request from the core");
        else
        begin
          c = issue_q.pop_front();
          check_value("data_addr_o", data_addr_o, field(c, F_A) + field(c, F_B), c);
          check_value("data_we_o", data_we_o, field(c, F_OP) != 0, c);
          check_value("data_be_o", data_be_o, field(c, F_BE), c);
          if (field(c, F_OP) != 0)
            check_value("data_wdata_o", data_wdata_o, field(c, F_LANES), c);
          check_value("load_err_o", load_err_o,
                      field(c, F_ERR) != 0 && field(c, F_OP) == 0, c);
          check_value("store_err_o", store_err_o,
                      field(c, F_ERR) != 0 && field(c, F_OP) != 0, c);
          resp_q.push_back(c);
        end
      end
    end
  end

endmodule

// File: load_store_unit.f
logic/lsu_pkg.sv
logic/lsu_addr_stage.sv
logic/lsu_req_ctrl.sv
logic/lsu_load_align.sv
logic/load_store_unit.sv
tb/lsu_mem_model.sv
tb/tb_load_store_unit.sv

// File: tb/lsu_cases.txt
// op(1 store) type sign operand_a operand_b wdata | exp be, exp wdata lanes, exp rdata, exp err
// stores first, then loads of every size, lane and extension
1 0 0 0000000c 00000004 8a7b3cf1 f 8a7b3cf1 00000000 0
1 2 0 0000001c 00000004 11223344 1 11223344 00000000 0
1 2 0 00000020 00000001 aabbcc95 2 bbcc95aa 00000000 0
1 2 0 00000022 00000000 00000066 4 00660000 00000000 0
1 3 0 00000030 fffffff3 123456e7 8 e7123456 00000000 0
1 1 0 00000030 00000000 dead7e01 3 dead7e01 00000000 0
1 1 0 00000031 00000001 5555f00d c f00d5555 00000000 0
1 0 0 80000000 00000010 0badf00d f 0badf00d 00000000 1
0 0 0 00000010 00000000 00000000 f 00000000 8a7b3cf1 0
0 1 0 00000010 00000000 00000000 3 00000000 00003cf1 0
0 1 1 00000008 00000008 00000000 3 00000000 00003cf1 0
0 1 0 00000012 00000000 00000000 c 00000000 00008a7b 0
0 1 1 00000002 00000010 00000000 c 00000000 ffff8a7b 0
0 1 1 00000030 00000000 00000000 3 00000000 00007e01 0
0 1 0 00000032 00000000 00000000 c 00000000 0000f00d 0
0 1 1 00000040 fffffff2 00000000 c 00000000 fffff00d 0
0 2 0 00000020 00000000 00000000 1 00000000 00000044 0
0 2 1 00000020 00000000 00000000 1 00000000 00000044 0
0 2 0 00000021 00000000 00000000 2 00000000 00000095 0
0 3 1 00000020 00000001 00000000 2 00000000 ffffff95 0
0 2 1 00000022 00000000 00000000 4 00000000 00000066 0
0 2 0 00000023 00000000 00000000 8 00000000 000000e7 0
0 2 1 00000023 00000000 00000000 8 00000000 ffffffe7 0
0 2 1 00000010 00000000 00000000 1 00000000 fffffff1 0
0 0 0 80000020 00000000 00000000 f 00000000 00000000 1
0 0 1 00000030 00000000 00000000 f 00000000 f00d7e01 0
0 0 0 00000020 00000000 00000000 f 00000000 e7669544 0
